// ==== common/axil_mem_pkg.sv ====
package axil_mem_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // AXI response codes, EXOKAY is never returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // Read channel pair
  typedef enum logic {
    RD_IDLE,
    RD_RESP
  } rd_state_e;

  // Write channel triple
  typedef enum logic {
    WR_COLLECT,
    WR_RESP
  } wr_state_e;

  // Address classification shared by both port kinds
  // Misaligned first, then anything above the last word
  function automatic resp_e check_addr(input addr_t addr, input int unsigned idx_w);
    resp_e resp;
    if (addr[1:0] != 2'b00) begin
      resp = RESP_SLVERR;
    end else if ((addr >> (idx_w + 2)) != '0) begin
      resp = RESP_DECERR;
    end else begin
      resp = RESP_OKAY;
    end
    return resp;
  endfunction

endpackage

// ==== memory_array/word_ram.sv ====
module word_ram #(
  parameter int NUM_WORDS = 1024
) (
  input  logic                axi,
  input  logic                rst,

  // Read port A
  input  logic                re_a,
  input  logic [$clog2(NUM_WORDS)-1:0] idx_a,
  output axil_mem_pkg::data_t rdata_a,

  // Read port B
  input  logic                re_b,
  input  logic [$clog2(NUM_WORDS)-1:0] idx_b,
  output axil_mem_pkg::data_t rdata_b,

  // Byte-strobed write port
  input  logic                we,
  input  logic [$clog2(NUM_WORDS)-1:0] widx,
  input  axil_mem_pkg::data_t wdata,
  input  axil_mem_pkg::strb_t wstrb
);

  // Array of 4-byte words
  axil_mem_pkg::data_t mem [NUM_WORDS];

  // Contents cleared on reset, then lane-wise writes
  always_ff @(posedge axi) begin
    if (rst) begin
      for (int w = 0; w < NUM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (we) begin
      for (int b = 0; b < axil_mem_pkg::STRB_W; b++) begin
        if (wstrb[b]) begin
          mem[widx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // Registered reads, old contents on a same-edge write
  // Output holds while the enable is low
  always_ff @(posedge axi) begin
    if (re_a) begin
      rdata_a <= mem[idx_a];
    end
    if (re_b) begin
      rdata_b <= mem[idx_b];
    end
  end

endmodule

// ==== hdl/axil_read_port.sv ====
module axil_read_port #(
  parameter int NUM_WORDS = 1024
) (
  input  logic                axi,
  input  logic                rst,

  // AR channel
  input  logic                arvalid,
  output logic                arready,
  input  axil_mem_pkg::addr_t araddr,

  // R channel
  output logic                rvalid,
  input  logic                rready,
  output axil_mem_pkg::data_t rdata,
  output axil_mem_pkg::resp_e rresp,

  // RAM read port
  output logic                ram_re,
  output logic [$clog2(NUM_WORDS)-1:0] ram_idx,
  input  axil_mem_pkg::data_t ram_rdata
);

  localparam int IDX_W = $clog2(NUM_WORDS);

  axil_mem_pkg::rd_state_e state;
  axil_mem_pkg::resp_e     ar_resp;
  axil_mem_pkg::resp_e     resp_q;
  logic                    ar_fire;
  logic                    r_fire;

  // Only one read in flight, so AR is open exactly while idle
  assign arready = (state == axil_mem_pkg::RD_IDLE);
  assign rvalid  = (state == axil_mem_pkg::RD_RESP);

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  // Classify the live address on the AR beat
  assign ar_resp = axil_mem_pkg::check_addr(araddr, IDX_W);

  // RAM captures the word on the AR edge
  // Bad addresses leave the RAM output register alone
  assign ram_re  = ar_fire && (ar_resp == axil_mem_pkg::RESP_OKAY);
  assign ram_idx = araddr[IDX_W+1:2];

  always_ff @(posedge axi) begin
    if (rst) begin
      state  <= axil_mem_pkg::RD_IDLE;
      resp_q <= axil_mem_pkg::RESP_OKAY;
    end else begin
      case (state)
        axil_mem_pkg::RD_IDLE: begin
          if (ar_fire) begin
            resp_q <= ar_resp;
            state  <= axil_mem_pkg::RD_RESP;
          end
        end
        axil_mem_pkg::RD_RESP: begin
          // Response held until the manager takes it
          if (r_fire) begin
            state <= axil_mem_pkg::RD_IDLE;
          end
        end
        default: begin
          state <= axil_mem_pkg::RD_IDLE;
        end
      endcase
    end
  end

  assign rresp = resp_q;

  // RAM word stays put under back-pressure since no new read is issued
  // Error responses carry zero data
  assign rdata = (resp_q == axil_mem_pkg::RESP_OKAY) ? ram_rdata : '0;

endmodule

// ==== hdl/axil_write_port.sv ====
module axil_write_port #(
  parameter int NUM_WORDS = 1024
) (
  input  logic                axi,
  input  logic                rst,

  // AW channel
  input  logic                awvalid,
  output logic                awready,
  input  axil_mem_pkg::addr_t awaddr,

  // W channel
  input  logic                wvalid,
  output logic                wready,
  input  axil_mem_pkg::data_t wdata,
  input  axil_mem_pkg::strb_t wstrb,

  // B channel
  output logic                bvalid,
  input  logic                bready,
  output axil_mem_pkg::resp_e bresp,

  // RAM write port
  output logic                ram_we,
  output logic [$clog2(NUM_WORDS)-1:0] ram_widx,
  output axil_mem_pkg::data_t ram_wdata,
  output axil_mem_pkg::strb_t ram_wstrb
);

  localparam int IDX_W = $clog2(NUM_WORDS);

  axil_mem_pkg::wr_state_e state;
  axil_mem_pkg::resp_e     wr_resp;
  axil_mem_pkg::resp_e     resp_q;

  // Capture flags for the two halves of a write
  logic aw_held;
  logic w_held;

  // Holding registers, payload only
  axil_mem_pkg::addr_t addr_q;
  axil_mem_pkg::data_t data_q;
  axil_mem_pkg::strb_t strb_q;

  // Held or live view of the write
  axil_mem_pkg::addr_t addr_sel;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic complete;

  // Each channel closes once its half is in
  assign awready = (state == axil_mem_pkg::WR_COLLECT) && !aw_held;
  assign wready  = (state == axil_mem_pkg::WR_COLLECT) && !w_held;
  assign bvalid  = (state == axil_mem_pkg::WR_RESP);

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;

  // Both halves present, whichever order they came in
  assign complete = (state == axil_mem_pkg::WR_COLLECT)
                    && (aw_held || aw_fire) && (w_held || w_fire);

  assign addr_sel  = aw_held ? addr_q : awaddr;
  assign ram_wdata = w_held ? data_q : wdata;
  assign ram_wstrb = w_held ? strb_q : wstrb;

  assign wr_resp  = axil_mem_pkg::check_addr(addr_sel, IDX_W);
  assign ram_widx = addr_sel[IDX_W+1:2];

  // Single write edge, good addresses only
  assign ram_we = complete && (wr_resp == axil_mem_pkg::RESP_OKAY);

  always_ff @(posedge axi) begin
    if (aw_fire) begin
      addr_q <= awaddr;
    end
    if (w_fire) begin
      data_q <= wdata;
      strb_q <= wstrb;
    end
  end

  always_ff @(posedge axi) begin
    if (rst) begin
      state   <= axil_mem_pkg::WR_COLLECT;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      resp_q  <= axil_mem_pkg::RESP_OKAY;
    end else begin
      case (state)
        axil_mem_pkg::WR_COLLECT: begin
          if (complete) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            resp_q  <= wr_resp;
            state   <= axil_mem_pkg::WR_RESP;
          end else begin
            // Only one half arrived, remember it
            if (aw_fire) begin
              aw_held <= 1'b1;
            end
            if (w_fire) begin
              w_held <= 1'b1;
            end
          end
        end
        axil_mem_pkg::WR_RESP: begin
          if (b_fire) begin
            state <= axil_mem_pkg::WR_COLLECT;
          end
        end
        default: begin
          state <= axil_mem_pkg::WR_COLLECT;
        end
      endcase
    end
  end

  assign bresp = resp_q;

endmodule

// ==== hdl/axil_dual_mem.sv ====
module axil_dual_mem #(
  parameter int NUM_WORDS = 1024
) (
  input  logic                axi,
  input  logic                rst,

  // Instruction port, read only
  input  logic                insn_arvalid,
  output logic                insn_arready,
  input  axil_mem_pkg::addr_t insn_araddr,
  output logic                insn_rvalid,
  input  logic                insn_rready,
  output axil_mem_pkg::data_t insn_rdata,
  output axil_mem_pkg::resp_e insn_rresp,

  // Data port, read channels
  input  logic                data_arvalid,
  output logic                data_arready,
  input  axil_mem_pkg::addr_t data_araddr,
  output logic                data_rvalid,
  input  logic                data_rready,
  output axil_mem_pkg::data_t data_rdata,
  output axil_mem_pkg::resp_e data_rresp,

  // Data port, write channels
  input  logic                data_awvalid,
  output logic                data_awready,
  input  axil_mem_pkg::addr_t data_awaddr,
  input  logic                data_wvalid,
  output logic                data_wready,
  input  axil_mem_pkg::data_t data_wdata,
  input  axil_mem_pkg::strb_t data_wstrb,
  output logic                data_bvalid,
  input  logic                data_bready,
  output axil_mem_pkg::resp_e data_bresp
);

  localparam int IDX_W = $clog2(NUM_WORDS);

  // RAM port A belongs to the instruction side
  logic                insn_ram_re;
  logic [IDX_W-1:0]    insn_ram_idx;
  axil_mem_pkg::data_t insn_ram_rdata;

  // RAM port B belongs to the data side
  logic                data_ram_re;
  logic [IDX_W-1:0]    data_ram_idx;
  axil_mem_pkg::data_t data_ram_rdata;

  // Write path
  logic                ram_we;
  logic [IDX_W-1:0]    ram_widx;
  axil_mem_pkg::data_t ram_wdata;
  axil_mem_pkg::strb_t ram_wstrb;

  axil_read_port #(
    .NUM_WORDS(NUM_WORDS)
  ) insn_rd (
    .axi      (axi),
    .rst      (rst),
    .arvalid  (insn_arvalid),
    .arready  (insn_arready),
    .araddr   (insn_araddr),
    .rvalid   (insn_rvalid),
    .rready   (insn_rready),
    .rdata    (insn_rdata),
    .rresp    (insn_rresp),
    .ram_re   (insn_ram_re),
    .ram_idx  (insn_ram_idx),
    .ram_rdata(insn_ram_rdata)
  );

  axil_read_port #(
    .NUM_WORDS(NUM_WORDS)
  ) data_rd (
    .axi      (axi),
    .rst      (rst),
    .arvalid  (data_arvalid),
    .arready  (data_arready),
    .araddr   (data_araddr),
    .rvalid   (data_rvalid),
    .rready   (data_rready),
    .rdata    (data_rdata),
    .rresp    (data_rresp),
    .ram_re   (data_ram_re),
    .ram_idx  (data_ram_idx),
    .ram_rdata(data_ram_rdata)
  );

  axil_write_port #(
    .NUM_WORDS(NUM_WORDS)
  ) data_wr (
    .axi      (axi),
    .rst      (rst),
    .awvalid  (data_awvalid),
    .awready  (data_awready),
    .awaddr   (data_awaddr),
    .wvalid   (data_wvalid),
    .wready   (data_wready),
    .wdata    (data_wdata),
    .wstrb    (data_wstrb),
    .bvalid   (data_bvalid),
    .bready   (data_bready),
    .bresp    (data_bresp),
    .ram_we   (ram_we),
    .ram_widx (ram_widx),
    .ram_wdata(ram_wdata),
    .ram_wstrb(ram_wstrb)
  );

  word_ram #(
    .NUM_WORDS(NUM_WORDS)
  ) ram (
    .axi    (axi),
    .rst    (rst),
    .re_a   (insn_ram_re),
    .idx_a  (insn_ram_idx),
    .rdata_a(insn_ram_rdata),
    .re_b   (data_ram_re),
    .idx_b  (data_ram_idx),
    .rdata_b(data_ram_rdata),
    .we     (ram_we),
    .widx   (ram_widx),
    .wdata  (ram_wdata),
    .wstrb  (ram_wstrb)
  );

endmodule

// ==== verification/axil_dual_mem_tb.sv ====
module axil_dual_mem_tb;

  localparam int NUM_WORDS      = 1024;
  localparam int TIMEOUT_CYCLES = 4000;

  logic axi;
  logic rst;

  // Instruction port
  logic                insn_arvalid;
  logic                insn_arready;
  axil_mem_pkg::addr_t insn_araddr;
  logic                insn_rvalid;
  logic                insn_rready;
  axil_mem_pkg::data_t insn_rdata;
  axil_mem_pkg::resp_e insn_rresp;

  // Data port
  logic                data_arvalid;
  logic                data_arready;
  axil_mem_pkg::addr_t data_araddr;
  logic                data_rvalid;
  logic                data_rready;
  axil_mem_pkg::data_t data_rdata;
  axil_mem_pkg::resp_e data_rresp;
  logic                data_awvalid;
  logic                data_awready;
  axil_mem_pkg::addr_t data_awaddr;
  logic                data_wvalid;
  logic                data_wready;
  axil_mem_pkg::data_t data_wdata;
  axil_mem_pkg::strb_t data_wstrb;
  logic                data_bvalid;
  logic                data_bready;
  axil_mem_pkg::resp_e data_bresp;

  // Expected memory contents
  axil_mem_pkg::data_t model [NUM_WORDS];
  int unsigned cycles = 0;

  axil_dual_mem #(
    .NUM_WORDS(NUM_WORDS)
  ) UUT (
    .axi         (axi),
    .rst         (rst),
    .insn_arvalid(insn_arvalid),
    .insn_arready(insn_arready),
    .insn_araddr (insn_araddr),
    .insn_rvalid (insn_rvalid),
    .insn_rready (insn_rready),
    .insn_rdata  (insn_rdata),
    .insn_rresp  (insn_rresp),
    .data_arvalid(data_arvalid),
    .data_arready(data_arready),
    .data_araddr (data_araddr),
    .data_rvalid (data_rvalid),
    .data_rready (data_rready),
    .data_rdata  (data_rdata),
    .data_rresp  (data_rresp),
    .data_awvalid(data_awvalid),
    .data_awready(data_awready),
    .data_awaddr (data_awaddr),
    .data_wvalid (data_wvalid),
    .data_wready (data_wready),
    .data_wdata  (data_wdata),
    .data_wstrb  (data_wstrb),
    .data_bvalid (data_bvalid),
    .data_bready (data_bready),
    .data_bresp  (data_bresp)
  );

  initial begin
    axi = 1'b0;
    forever begin
      #4 axi = ~axi;
    end
  end

  // Run limit far above the length of the whole test sequence
  always @(posedge axi) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a handshake never completed", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  // Advance one clock so stimulus lands just after the edge
  task automatic tick;
    @(posedge axi);
    #1;
  endtask

  task automatic check_data(input string name, input axil_mem_pkg::data_t exp,
                            input axil_mem_pkg::data_t act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_resp(input string name, input axil_mem_pkg::resp_e exp,
                            input axil_mem_pkg::resp_e act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("TB FAILED");
      $fatal(1, "control level mismatch");
    end
  endtask

  // Misaligned wins over out of range
  function automatic axil_mem_pkg::resp_e exp_resp(input axil_mem_pkg::addr_t addr);
    if (addr[1:0] != 2'b00) begin
      return axil_mem_pkg::RESP_SLVERR;
    end
    if (addr >= axil_mem_pkg::addr_t'(NUM_WORDS * 4)) begin
      return axil_mem_pkg::RESP_DECERR;
    end
    return axil_mem_pkg::RESP_OKAY;
  endfunction

  // Lane-wise merge of a strobed write
  function automatic axil_mem_pkg::data_t merge_lanes(input axil_mem_pkg::data_t old_word,
                                                      input axil_mem_pkg::data_t new_word,
                                                      input axil_mem_pkg::strb_t strb);
    axil_mem_pkg::data_t res;
    res = old_word;
    for (int b = 0; b < axil_mem_pkg::STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic int word_of(input axil_mem_pkg::addr_t addr);
    return int'((addr >> 2) % NUM_WORDS);
  endfunction

  function automatic axil_mem_pkg::addr_t rand_addr;
    return axil_mem_pkg::addr_t'($urandom % NUM_WORDS) << 2;
  endfunction

  // Port select helpers where insn high picks the instruction port
  task automatic drive_ar(input bit insn, input logic valid, input axil_mem_pkg::addr_t addr);
    if (insn) begin
      insn_arvalid = valid;
      insn_araddr  = addr;
    end else begin
      data_arvalid = valid;
      data_araddr  = addr;
    end
  endtask

  task automatic drive_rready(input bit insn, input logic ready);
    if (insn) begin
      insn_rready = ready;
    end else begin
      data_rready = ready;
    end
  endtask

  function automatic logic arready_of(input bit insn);
    return insn ? insn_arready : data_arready;
  endfunction

  function automatic logic rvalid_of(input bit insn);
    return insn ? insn_rvalid : data_rvalid;
  endfunction

  function automatic axil_mem_pkg::data_t rdata_of(input bit insn);
    return insn ? insn_rdata : data_rdata;
  endfunction

  function automatic axil_mem_pkg::resp_e rresp_of(input bit insn);
    return insn ? insn_rresp : data_rresp;
  endfunction

  // AR then R, with rready held low for rdelay cycles
  task automatic do_read(input bit insn, input axil_mem_pkg::addr_t addr, input int rdelay,
                         output axil_mem_pkg::data_t data, output axil_mem_pkg::resp_e resp);
    string p;
    p = insn ? "insn_" : "data_";
    drive_ar(insn, 1'b1, addr);
    while (!arready_of(insn)) begin
      tick();
    end
    check_bit({p, "rvalid"}, 1'b0, rvalid_of(insn));
    tick();
    drive_ar(insn, 1'b0, '0);
    // Exactly one cycle after the AR beat
    check_bit({p, "rvalid"}, 1'b1, rvalid_of(insn));
    check_bit({p, "arready"}, 1'b0, arready_of(insn));
    data = rdata_of(insn);
    resp = rresp_of(insn);
    // Response must hold under back-pressure
    repeat (rdelay) begin
      tick();
      check_bit({p, "rvalid"}, 1'b1, rvalid_of(insn));
      check_data({p, "rdata"}, data, rdata_of(insn));
      check_resp({p, "rresp"}, resp, rresp_of(insn));
      check_bit({p, "arready"}, 1'b0, arready_of(insn));
    end
    drive_rready(insn, 1'b1);
    tick();
    drive_rready(insn, 1'b0);
    check_bit({p, "rvalid"}, 1'b0, rvalid_of(insn));
    check_bit({p, "arready"}, 1'b1, arready_of(insn));
  endtask

  task automatic send_aw(input axil_mem_pkg::addr_t addr);
    data_awvalid = 1'b1;
    data_awaddr  = addr;
    while (!data_awready) begin
      tick();
    end
    tick();
    data_awvalid = 1'b0;
    // Bus no longer carries the address once AW is taken
    data_awaddr  = ~addr;
  endtask

  task automatic send_w(input axil_mem_pkg::data_t data, input axil_mem_pkg::strb_t strb);
    data_wvalid = 1'b1;
    data_wdata  = data;
    data_wstrb  = strb;
    while (!data_wready) begin
      tick();
    end
    tick();
    data_wvalid = 1'b0;
    // Bus no longer carries the data once W is taken
    data_wdata  = ~data;
    data_wstrb  = ~strb;
  endtask

  // Order 0 sends AW and W together, 1 sends AW first, 2 sends W first
  task automatic do_write(input axil_mem_pkg::addr_t addr, input axil_mem_pkg::data_t data,
                          input axil_mem_pkg::strb_t strb, input int order, input int bdelay,
                          output axil_mem_pkg::resp_e resp);
    if (order == 1) begin
      send_aw(addr);
      check_bit("data_awready", 1'b0, data_awready);
      check_bit("data_wready", 1'b1, data_wready);
      check_bit("data_bvalid", 1'b0, data_bvalid);
      send_w(data, strb);
    end else if (order == 2) begin
      send_w(data, strb);
      check_bit("data_wready", 1'b0, data_wready);
      check_bit("data_awready", 1'b1, data_awready);
      check_bit("data_bvalid", 1'b0, data_bvalid);
      send_aw(addr);
    end else begin
      data_awvalid = 1'b1;
      data_awaddr  = addr;
      data_wvalid  = 1'b1;
      data_wdata   = data;
      data_wstrb   = strb;
      while (!(data_awready && data_wready)) begin
        tick();
      end
      tick();
      data_awvalid = 1'b0;
      data_wvalid  = 1'b0;
    end
    // B follows the completing edge by one cycle
    check_bit("data_bvalid", 1'b1, data_bvalid);
    check_bit("data_awready", 1'b0, data_awready);
    check_bit("data_wready", 1'b0, data_wready);
    resp = data_bresp;
    repeat (bdelay) begin
      tick();
      check_bit("data_bvalid", 1'b1, data_bvalid);
      check_resp("data_bresp", resp, data_bresp);
      check_bit("data_awready", 1'b0, data_awready);
      check_bit("data_wready", 1'b0, data_wready);
    end
    data_bready = 1'b1;
    tick();
    data_bready = 1'b0;
    check_bit("data_bvalid", 1'b0, data_bvalid);
    check_bit("data_awready", 1'b1, data_awready);
    check_bit("data_wready", 1'b1, data_wready);
  endtask

  // Write and keep the model in step
  task automatic write_check(input axil_mem_pkg::addr_t addr, input axil_mem_pkg::data_t data,
                             input axil_mem_pkg::strb_t strb, input int order,
                             input int bdelay);
    axil_mem_pkg::resp_e resp;
    axil_mem_pkg::resp_e exp;
    exp = exp_resp(addr);
    do_write(addr, data, strb, order, bdelay, resp);
    check_resp("data_bresp", exp, resp);
    if (exp == axil_mem_pkg::RESP_OKAY) begin
      model[word_of(addr)] = merge_lanes(model[word_of(addr)], data, strb);
    end
  endtask

  // Error reads must carry zero data
  task automatic read_check(input bit insn, input axil_mem_pkg::addr_t addr, input int rdelay);
    axil_mem_pkg::data_t data;
    axil_mem_pkg::resp_e resp;
    axil_mem_pkg::resp_e exp;
    exp = exp_resp(addr);
    do_read(insn, addr, rdelay, data, resp);
    check_resp(insn ? "insn_rresp" : "data_rresp", exp, resp);
    if (exp == axil_mem_pkg::RESP_OKAY) begin
      check_data(insn ? "insn_rdata" : "data_rdata", model[word_of(addr)], data);
    end else begin
      check_data(insn ? "insn_rdata" : "data_rdata", '0, data);
    end
  endtask

  task automatic reset_state;
    axil_mem_pkg::addr_t addr;
    check_bit("insn_arready", 1'b1, insn_arready);
    check_bit("data_arready", 1'b1, data_arready);
    check_bit("data_awready", 1'b1, data_awready);
    check_bit("data_wready", 1'b1, data_wready);
    check_bit("insn_rvalid", 1'b0, insn_rvalid);
    check_bit("data_rvalid", 1'b0, data_rvalid);
    check_bit("data_bvalid", 1'b0, data_bvalid);
    check_resp("insn_rresp", axil_mem_pkg::RESP_OKAY, insn_rresp);
    check_resp("data_rresp", axil_mem_pkg::RESP_OKAY, data_rresp);
    check_resp("data_bresp", axil_mem_pkg::RESP_OKAY, data_bresp);
    read_check(1'b1, '0, 0);
    read_check(1'b0, axil_mem_pkg::addr_t'((NUM_WORDS - 1) * 4), 0);
    repeat (4) begin
      addr = rand_addr();
      read_check(1'b1, addr, 0);
      read_check(1'b0, addr, 0);
    end
  endtask

  task automatic full_word_rw;
    axil_mem_pkg::addr_t addr;
    repeat (16) begin
      addr = rand_addr();
      write_check(addr, $urandom, 4'hf, 0, 0);
      read_check(1'b1, addr, 0);
      read_check(1'b0, addr, 0);
    end
  endtask

  // Every strobe pattern from single lanes to mixed
  task automatic byte_strobe_rw;
    axil_mem_pkg::addr_t addr;
    addr = rand_addr();
    write_check(addr, $urandom, 4'hf, 0, 0);
    for (int s = 1; s < 16; s++) begin
      write_check(addr, $urandom, axil_mem_pkg::strb_t'(s), 0, 0);
      read_check(1'b0, addr, 0);
      read_check(1'b1, addr, 0);
    end
  endtask

  task automatic write_ordering;
    axil_mem_pkg::addr_t addr;
    for (int order = 0; order < 3; order++) begin
      addr = rand_addr();
      write_check(addr, $urandom, 4'hf, order, 5);
      write_check(addr, $urandom, 4'h5, order, 0);
      read_check(1'b0, addr, 0);
    end
  endtask

  task automatic address_errors;
    axil_mem_pkg::addr_t base;
    axil_mem_pkg::addr_t far;
    base = rand_addr();
    write_check(base, $urandom, 4'hf, 0, 0);
    for (int off = 1; off < 4; off++) begin
      read_check(1'b1, base + off, 0);
      read_check(1'b0, base + off, 0);
      write_check(base + off, $urandom, 4'hf, off - 1, 0);
    end
    read_check(1'b0, base, 0);
    // First word past the end and then a random far address
    far = axil_mem_pkg::addr_t'(NUM_WORDS * 4);
    repeat (2) begin
      read_check(1'b1, far, 0);
      read_check(1'b0, far, 2);
      write_check(far, $urandom, 4'hf, 0, 0);
      read_check(1'b0, far & axil_mem_pkg::addr_t'(NUM_WORDS * 4 - 1), 0);
      far = far + (rand_addr() << 4);
    end
  endtask

  // Data port stalls while the instruction port finishes its own read
  task automatic r_backpressure;
    axil_mem_pkg::addr_t addr_a;
    axil_mem_pkg::addr_t addr_b;
    addr_a = rand_addr();
    addr_b = addr_a ^ 32'h0000_0040;
    write_check(addr_a, $urandom, 4'hf, 0, 0);
    write_check(addr_b, $urandom, 4'hf, 0, 0);
    fork
      begin
        read_check(1'b0, addr_a, 8);
      end
      begin
        read_check(1'b1, addr_b, 0);
        check_bit("data_rvalid", 1'b1, data_rvalid);
        check_bit("data_arready", 1'b0, data_arready);
      end
    join
  endtask

  initial begin
    void'($urandom(32'hd30c_d376));
    rst          = 1'b1;
    insn_arvalid = 1'b0;
    insn_araddr  = '0;
    insn_rready  = 1'b0;
    data_arvalid = 1'b0;
    data_araddr  = '0;
    data_rready  = 1'b0;
    data_awvalid = 1'b0;
    data_awaddr  = '0;
    data_wvalid  = 1'b0;
    data_wdata   = '0;
    data_wstrb   = '0;
    data_bready  = 1'b0;
    for (int w = 0; w < NUM_WORDS; w++) begin
      model[w] = '0;
    end
    repeat (10) begin
      @(posedge axi);
    end
    #1;
    rst = 1'b0;
    tick();
    reset_state();
    full_word_rw();
    byte_strobe_rw();
    write_ordering();
    address_errors();
    r_backpressure();
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== build.f ====
common/axil_mem_pkg.sv
memory_array/word_ram.sv
hdl/axil_read_port.sv
hdl/axil_write_port.sv
hdl/axil_dual_mem.sv
verification/axil_dual_mem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  -f build.f \
  --top-module axil_dual_mem_tb \
  --Mdir obj_dir \
  -o axil_dual_mem_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/axil_dual_mem_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0
